// File: rtl/spin_link_defines.svh
`ifndef SPIN_LINK_DEFINES_SVH
`define SPIN_LINK_DEFINES_SVH

// Spin vector width from the analog macro
`define SPIN_NUM 64

// Maximum synchronizer stages
`define SYNC_DEPTH 3

// Receive buffer entries
`define RX_DEPTH 4

// Credit counter width, must hold RX_DEPTH
`define CREDIT_W 3

// Stage select width, covers 0 to SYNC_DEPTH
`define PIPE_SEL_W 2

`endif

// File: rtl/spin_pkg.sv
`include "spin_link_defines.svh"

package spin_pkg;

    // One spin vector as seen by the digital side
    typedef logic [`SPIN_NUM-1:0] spin_t;

    // Read and write pointers of the receive buffer
    typedef logic [1:0] rx_ptr_t;

    // Credits held by the transmitter
    typedef logic [`CREDIT_W-1:0] credit_t;

endpackage

// File: rtl/ctrl_pkg.sv
`include "spin_link_defines.svh"

package ctrl_pkg;

    // Number of synchronizer stages in use
    typedef logic [`PIPE_SEL_W-1:0] pipe_sel_t;

    // Synchronizer behaviour
    typedef enum logic {
        SYNC_ONESHOT = 1'b0,
        SYNC_CONT    = 1'b1
    } sync_mode_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        SETTLE      = 2'b01,
        WAIT_CREDIT = 2'b10,
        IDLE        = 2'b00
    } tx_state_e;

endpackage

// File: rtl/step_counter.sv
`timescale 1ns/1ps

module step_counter (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                en_i,
    input  logic                load_i,
    input  ctrl_pkg::pipe_sel_t d_i,
    input  logic                step_i,
    output ctrl_pkg::pipe_sel_t q_o,
    output logic                done_o
);
    ctrl_pkg::pipe_sel_t count_q;
    logic                active_q;

    // Counter runs only between a load and its run-out
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            active_q <= 1'b0;
        end else if (en_i) begin
            if (load_i) begin
                count_q  <= d_i;
                active_q <= 1'b1;
            end else if (active_q && step_i) begin
                if (count_q == '0) begin
                    active_q <= 1'b0;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    // Run-out flag, a load of zero fires on the next enabled cycle
    assign done_o = en_i & active_q & step_i & (count_q == '0);
    assign q_o    = count_q;

endmodule

// File: rtl/analog_tx.sv
`timescale 1ns/1ps
`include "spin_link_defines.svh"

module analog_tx (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 cfg_load_i,
    input  ctrl_pkg::pipe_sel_t  cfg_pipe_sel_i,
    input  ctrl_pkg::sync_mode_e cfg_mode_i,
    input  spin_pkg::spin_t      spin_i,
    input  logic                 cmpt_finish_i,
    input  logic                 credit_return_i,
    output logic                 push_o,
    output spin_pkg::spin_t      push_spin_o,
    output logic                 idle_o,
    output logic                 overrun_o
);
    ctrl_pkg::pipe_sel_t                 pipe_sel_q;
    ctrl_pkg::sync_mode_e                mode_q;
    ctrl_pkg::tx_state_e                 state_q;
    ctrl_pkg::tx_state_e                 state_d;
    spin_pkg::credit_t                   credit_q;
    spin_pkg::spin_t                     pending_q;
    spin_pkg::spin_t                     sel_spin;
    spin_pkg::spin_t [`SYNC_DEPTH:1]     sync_q;
    spin_pkg::spin_t [`SYNC_DEPTH:0]     chain;
    logic            [`SYNC_DEPTH-1:1]   pulse_q;
    logic            [`SYNC_DEPTH-1:0]   pulse_chain;
    logic                                finish_q;
    logic                                finish_edge;
    logic                                accept;
    logic                                count_done;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pipe_sel_q <= ctrl_pkg::pipe_sel_t'(`SYNC_DEPTH - 1);
            mode_q     <= ctrl_pkg::SYNC_ONESHOT;
        end else if (en_i && cfg_load_i) begin
            pipe_sel_q <= cfg_pipe_sel_i;
            mode_q     <= cfg_mode_i;
        end
    end

    // Rising edge of the finish line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            finish_q <= 1'b0;
        end else if (en_i) begin
            finish_q <= cmpt_finish_i;
        end
    end

    assign finish_edge = en_i & cmpt_finish_i & ~finish_q;
    // A new edge is taken when idle or while the waiting word leaves
    assign accept      = finish_edge & ((state_q == ctrl_pkg::IDLE) | push_o);

    // Stage 0 is the raw analog input
    assign chain       = {sync_q, spin_i};
    assign pulse_chain = {pulse_q, accept};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pulse_q <= '0;
        end else if (en_i) begin
            pulse_q <= pulse_chain[`SYNC_DEPTH-2:0];
        end
    end

    // One-shot follows the pulse chain while continuous shifts every cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            for (int i = 1; i <= `SYNC_DEPTH; i++) begin
                if (mode_q == ctrl_pkg::SYNC_CONT || pulse_chain[i-1]) begin
                    sync_q[i] <= chain[i-1];
                end
            end
        end
    end

    assign sel_spin = chain[pipe_sel_q];

    step_counter u_step_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (en_i),
        .load_i  (accept),
        .d_i     (pipe_sel_q),
        .step_i  (state_q == ctrl_pkg::SETTLE),
        .q_o     (),
        .done_o  (count_done)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrl_pkg::IDLE: begin
                if (accept) state_d = ctrl_pkg::SETTLE;
            end
            ctrl_pkg::SETTLE: begin
                if (count_done) state_d = ctrl_pkg::WAIT_CREDIT;
            end
            ctrl_pkg::WAIT_CREDIT: begin
                if (push_o) state_d = accept ? ctrl_pkg::SETTLE : ctrl_pkg::IDLE;
            end
            default: state_d = ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ctrl_pkg::IDLE;
        end else if (en_i) begin
            state_q <= state_d;
        end
    end

    // Word taken at run-out
    always_ff @(posedge clk_i) begin
        if (en_i && state_q == ctrl_pkg::SETTLE && count_done) begin
            pending_q <= sel_spin;
        end
    end

    // Returns keep counting while disabled since the buffer drains on its own
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_q <= spin_pkg::credit_t'(`RX_DEPTH);
        end else if (push_o && !credit_return_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (!push_o && credit_return_i) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            overrun_o <= 1'b0;
        end else if (en_i && cfg_load_i) begin
            overrun_o <= 1'b0;
        end else if (finish_edge && !accept) begin
            overrun_o <= 1'b1;
        end
    end

    assign push_o      = en_i & (state_q == ctrl_pkg::WAIT_CREDIT) & (credit_q != '0);
    assign push_spin_o = pending_q;
    assign idle_o      = (state_q == ctrl_pkg::IDLE);

endmodule

// File: rtl/spin_rx_buffer.sv
`timescale 1ns/1ps
`include "spin_link_defines.svh"

module spin_rx_buffer (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            push_i,
    input  spin_pkg::spin_t push_spin_i,
    input  logic            pop_i,
    output spin_pkg::spin_t spin_o,
    output logic            valid_o,
    output logic            full_o,
    output logic            credit_return_o
);
    spin_pkg::spin_t       mem [`RX_DEPTH];
    spin_pkg::rx_ptr_t     wr_ptr_q;
    spin_pkg::rx_ptr_t     rd_ptr_q;
    logic [`CREDIT_W-1:0]  occ_q;
    logic                  pop_ok;

    // Pops on an empty buffer are dropped
    assign pop_ok = pop_i & valid_o;

    // Credits guarantee a free slot on every push
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_spin_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (push_i) begin
            if (wr_ptr_q == spin_pkg::rx_ptr_t'(`RX_DEPTH - 1)) begin
                wr_ptr_q <= '0;
            end else begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (pop_ok) begin
            if (rd_ptr_q == spin_pkg::rx_ptr_t'(`RX_DEPTH - 1)) begin
                rd_ptr_q <= '0;
            end else begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            occ_q <= '0;
        end else if (push_i && !pop_ok) begin
            occ_q <= occ_q + 1'b1;
        end else if (!push_i && pop_ok) begin
            occ_q <= occ_q - 1'b1;
        end
    end

    // One credit back per popped entry
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= pop_ok;
        end
    end

    assign spin_o  = mem[rd_ptr_q];
    assign valid_o = (occ_q != '0);
    assign full_o  = (occ_q == `CREDIT_W'(`RX_DEPTH));

endmodule

// File: rtl/spin_link_top.sv
`timescale 1ns/1ps

module spin_link_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 cfg_load_i,
    input  ctrl_pkg::pipe_sel_t  cfg_pipe_sel_i,
    input  ctrl_pkg::sync_mode_e cfg_mode_i,
    input  spin_pkg::spin_t      spin_i,
    input  logic                 cmpt_finish_i,
    input  logic                 spin_pop_i,
    output spin_pkg::spin_t      spin_o,
    output logic                 spin_valid_o,
    output logic                 buffer_full_o,
    output logic                 tx_idle_o,
    output logic                 overrun_o
);
    // Credit link between transmitter and buffer
    logic            push;
    spin_pkg::spin_t push_spin;
    logic            credit_return;

    analog_tx u_analog_tx (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .en_i            (en_i),
        .cfg_load_i      (cfg_load_i),
        .cfg_pipe_sel_i  (cfg_pipe_sel_i),
        .cfg_mode_i      (cfg_mode_i),
        .spin_i          (spin_i),
        .cmpt_finish_i   (cmpt_finish_i),
        .credit_return_i (credit_return),
        .push_o          (push),
        .push_spin_o     (push_spin),
        .idle_o          (tx_idle_o),
        .overrun_o       (overrun_o)
    );

    // Drain side pops straight from the buffer head
    spin_rx_buffer u_spin_rx_buffer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .push_i          (push),
        .push_spin_i     (push_spin),
        .pop_i           (spin_pop_i),
        .spin_o          (spin_o),
        .valid_o         (spin_valid_o),
        .full_o          (buffer_full_o),
        .credit_return_o (credit_return)
    );

endmodule

// File: sim/tb_spin_link.sv
`timescale 1ns/1ps
`include "spin_link_defines.svh"

module tb_spin_link;

    localparam int          TIMEOUT   = 200;
    localparam logic [15:0] LFSR_SEED = 16'd28674;
    localparam int          W_IDLE    = 0;
    localparam int          W_FULL    = 1;
    localparam int          W_OVERRUN = 2;
    localparam int          W_DRAINED = 3;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 en_i;
    logic                 cfg_load_i;
    ctrl_pkg::pipe_sel_t  cfg_pipe_sel_i;
    ctrl_pkg::sync_mode_e cfg_mode_i;
    spin_pkg::spin_t      spin_i;
    logic                 cmpt_finish_i;
    logic                 spin_pop_i;
    spin_pkg::spin_t      spin_o;
    logic                 spin_valid_o;
    logic                 buffer_full_o;
    logic                 tx_idle_o;
    logic                 overrun_o;

    // Words still expected on the drain side, oldest first
    spin_pkg::spin_t      exp_q[$];
    logic [15:0]          data_lfsr;
    logic [15:0]          pop_lfsr;
    logic                 drain_en;
    ctrl_pkg::sync_mode_e cur_mode;
    string                test_name;
    spin_pkg::spin_t      word;

    spin_link_top uut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (en_i),
        .cfg_load_i     (cfg_load_i),
        .cfg_pipe_sel_i (cfg_pipe_sel_i),
        .cfg_mode_i     (cfg_mode_i),
        .spin_i         (spin_i),
        .cmpt_finish_i  (cmpt_finish_i),
        .spin_pop_i     (spin_pop_i),
        .spin_o         (spin_o),
        .spin_valid_o   (spin_valid_o),
        .buffer_full_o  (buffer_full_o),
        .tx_idle_o      (tx_idle_o),
        .overrun_o      (overrun_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // 16-bit Galois LFSR, one step per random bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // Expected word for one finish event
    function automatic spin_pkg::spin_t ref_capture(input ctrl_pkg::sync_mode_e mode,
                                                    input spin_pkg::spin_t edge_spin,
                                                    input spin_pkg::spin_t window_spin);
        if (mode == ctrl_pkg::SYNC_CONT) begin
            return window_spin;
        end
        return edge_spin;
    endfunction

    function automatic logic cond_met(input int which);
        case (which)
            W_IDLE:    return tx_idle_o;
            W_FULL:    return buffer_full_o;
            W_OVERRUN: return overrun_o;
            default:   return (exp_q.size() == 0) && !spin_valid_o && tx_idle_o;
        endcase
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input spin_pkg::spin_t expected,
                               input spin_pkg::spin_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        while (!cond_met(which) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!cond_met(which)) begin
            $display("Timeout in %s: %s did not happen", test_name, what);
            abort_run();
        end
    endtask

    task automatic gen_spin(output spin_pkg::spin_t w);
        for (int i = 0; i < `SPIN_NUM; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            w[i] = data_lfsr[0];
        end
    endtask

    task automatic load_cfg(input int sel, input ctrl_pkg::sync_mode_e mode);
        cfg_pipe_sel_i = ctrl_pkg::pipe_sel_t'(sel);
        cfg_mode_i     = mode;
        cfg_load_i     = 1'b1;
        cur_mode       = mode;
        @(negedge clk_i);
        cfg_load_i     = 1'b0;
    endtask

    // Spin held stable around a one-cycle finish pulse, then scrambled
    task automatic issue_finish(input spin_pkg::spin_t w, input logic accepted);
        spin_pkg::spin_t scramble;
        spin_i = w;
        next_cycles(`SYNC_DEPTH + 2);
        cmpt_finish_i = 1'b1;
        if (accepted) begin
            exp_q.push_back(ref_capture(cur_mode, w, w));
        end
        @(negedge clk_i);
        cmpt_finish_i = 1'b0;
        next_cycles(`SYNC_DEPTH + 2);
        gen_spin(scramble);
        spin_i = scramble;
    endtask

    // Drain side, random pops compared against the expected queue
    initial begin : compare_proc
        spin_pkg::spin_t head;
        forever begin
            @(negedge clk_i);
            spin_pop_i = 1'b0;
            if (drain_en && spin_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("In %s a word was presented while none was expected", test_name);
                    abort_run();
                end else begin
                    pop_lfsr = lfsr_next(pop_lfsr);
                    if (pop_lfsr[0]) begin
                        head = exp_q.pop_front();
                        check_value(test_name, head, spin_o);
                        spin_pop_i = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main_proc
        rst_n_i        = 1'b0;
        en_i           = 1'b0;
        cfg_load_i     = 1'b0;
        cfg_pipe_sel_i = '0;
        cfg_mode_i     = ctrl_pkg::SYNC_ONESHOT;
        spin_i         = '0;
        cmpt_finish_i  = 1'b0;
        spin_pop_i     = 1'b0;
        data_lfsr      = LFSR_SEED;
        pop_lfsr       = LFSR_SEED;
        drain_en       = 1'b0;
        cur_mode       = ctrl_pkg::SYNC_ONESHOT;
        test_name      = "reset";
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        en_i    = 1'b1;
        @(negedge clk_i);
        check_value("reset_valid", '0, spin_valid_o);
        check_value("reset_overrun", '0, overrun_o);
        check_value("reset_full", '0, buffer_full_o);
        check_value("reset_idle", 1, tx_idle_o);

        // One-shot capture with a live consumer
        drain_en = 1'b1;
        for (int sel = 0; sel < 3; sel++) begin
            test_name = $sformatf("oneshot_sel%0d", sel);
            load_cfg(sel, ctrl_pkg::SYNC_ONESHOT);
            for (int k = 0; k < 4; k++) begin
                wait_for(W_IDLE, "transmitter idle");
                gen_spin(word);
                issue_finish(word, 1'b1);
            end
            wait_for(W_DRAINED, "drain of all words");
        end

        // No pops, so credits run out after four words
        test_name = "backpressure";
        drain_en  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            wait_for(W_IDLE, "transmitter idle");
            gen_spin(word);
            issue_finish(word, 1'b1);
        end
        wait_for(W_FULL, "buffer full");
        wait_for(W_IDLE, "transmitter idle");
        gen_spin(word);
        issue_finish(word, 1'b1);
        check_value("backpressure_waiting", '0, tx_idle_o);
        check_value("backpressure_full", 1, buffer_full_o);
        gen_spin(word);
        issue_finish(word, 1'b0);
        wait_for(W_OVERRUN, "overrun flag");
        drain_en = 1'b1;
        wait_for(W_DRAINED, "drain of five words");
        next_cycles(8);
        check_value("backpressure_no_sixth", '0, spin_valid_o);
        check_value("overrun_sticky", 1, overrun_o);

        test_name = "cfg_clear";
        load_cfg(2, ctrl_pkg::SYNC_CONT);
        check_value("cfg_clear_overrun", '0, overrun_o);

        // Continuous shifting over a long stable window
        for (int sel = 0; sel <= `SYNC_DEPTH; sel++) begin
            test_name = $sformatf("continuous_sel%0d", sel);
            load_cfg(sel, ctrl_pkg::SYNC_CONT);
            gen_spin(word);
            spin_i = word;
            next_cycles(2 * `SYNC_DEPTH);
            issue_finish(word, 1'b1);
            wait_for(W_DRAINED, "drain of continuous word");
        end

        // Finish edge while disabled is ignored
        test_name = "enable_low";
        load_cfg(1, ctrl_pkg::SYNC_ONESHOT);
        en_i = 1'b0;
        gen_spin(word);
        spin_i = word;
        @(negedge clk_i);
        cmpt_finish_i = 1'b1;
        next_cycles(2);
        cmpt_finish_i = 1'b0;
        next_cycles(3);
        en_i = 1'b1;
        next_cycles(12);
        check_value("enable_low_idle", 1, tx_idle_o);
        check_value("enable_low_valid", '0, spin_valid_o);

        $display("sim passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/spin_pkg.sv
rtl/ctrl_pkg.sv
rtl/step_counter.sv
rtl/analog_tx.sv
rtl/spin_rx_buffer.sv
rtl/spin_link_top.sv
sim/tb_spin_link.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_spin_link -Mdir obj_dir
	-obj_dir/Vtb_spin_link > sim.log 2>&1
	cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
